// ==== design/corr_data_pkg.sv ====
`default_nettype none

package corr_data_pkg;

    typedef logic signed [15:0] sample_t;   // input sample
    typedef logic signed [15:0] coef_t;     // tap coefficient
    typedef logic signed [47:0] prod_t;     // multiplier slice output width
    typedef logic signed [47:0] corr_t;     // correlation sum

    // pipeline depths seen from the data path
    localparam int MULT_LAT = 4;            // a1/b1, a2/b2, m, p
    localparam int SUM_LAT  = 2;            // adder tree then compare

    // correlator result as seen at the top level
    typedef struct packed {
        logic  valid;                       // one pulse per accepted sample
        corr_t value;                       // signed correlation
        logic  peak;                        // value above threshold
    } corr_out_t;                           // 50 bits

endpackage

`default_nettype wire

// ==== design/corr_cfg_pkg.sv ====
`default_nettype none

package corr_cfg_pkg;

    typedef logic [3:0]  cfg_addr_t;        // register address
    typedef logic [31:0] cfg_data_t;        // write data word

    // coefficients sit at 0 .. NUM_TAPS-1, threshold at the top of the map
    localparam cfg_addr_t THRESH_ADDR = cfg_addr_t'(15);

    typedef struct packed {
        logic      en;                      // single cycle write strobe
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

endpackage

`default_nettype wire

// ==== design/coef_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_regs #(
    parameter int NUM_TAPS = 8                          // number of coefficient registers
)
(
    input  logic                                  clk,
    input  logic                                  arst_n,

    input  corr_cfg_pkg::cfg_wr_t                 cfg,     // write port
    output corr_data_pkg::coef_t [NUM_TAPS-1:0]   coefs,   // to the multipliers
    output corr_data_pkg::corr_t                  thresh   // to the peak compare
);

corr_data_pkg::coef_t [NUM_TAPS-1:0] coef_r;           // coefficient bank
corr_data_pkg::corr_t                thresh_r;         // sign extended threshold

// coefficient bank, low half of the data word is kept
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        coef_r <= '0;                                   // all taps start at zero
    end else if (cfg.en) begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (cfg.addr == corr_cfg_pkg::cfg_addr_t'(i)) begin
                coef_r[i] <= corr_data_pkg::coef_t'(cfg.data[15:0]);
            end
        end
    end
end

// threshold register
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        thresh_r <= '0;
    end else if (cfg.en && (cfg.addr == corr_cfg_pkg::THRESH_ADDR)) begin
        thresh_r <= {{16{cfg.data[31]}}, cfg.data};     // 32 -> 48 sign extension
    end
end

// addresses between NUM_TAPS and 14 match nothing and are dropped

assign coefs  = coef_r;
assign thresh = thresh_r;

endmodule

`default_nettype wire

// ==== design/sample_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line #(
    parameter int NUM_TAPS = 8                            // delay line length
)
(
    input  logic                                    clk,
    input  logic                                    arst_n,

    input  corr_data_pkg::sample_t                  sample,        // new sample
    input  logic                                    sample_valid,  // one cycle strobe
    output corr_data_pkg::sample_t [NUM_TAPS-1:0]   taps,          // [0] is newest
    output logic                                    taps_valid     // taps just shifted
);

corr_data_pkg::sample_t [NUM_TAPS-1:0] line_r;           // the shift register
logic                                  shifted_r;        // strobe delayed by one

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        line_r <= '0;                                     // unfilled taps read as zero
    end else if (sample_valid) begin
        line_r[0] <= sample;                              // newest in at the head
        for (int i = 1; i < NUM_TAPS; i++) begin
            line_r[i] <= line_r[i-1];                     // older samples move down
        end
    end
end

// taps hold between strobes so gaps in the stream do not change the result

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        shifted_r <= 1'b0;
    end else begin
        shifted_r <= sample_valid;                        // follows the shift by a cycle
    end
end

assign taps       = line_r;
assign taps_valid = shifted_r;

endmodule

`default_nettype wire

// ==== design/tap_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_mult
(
    input  logic                      clk,
    input  logic                      arst_n,

    input  corr_data_pkg::sample_t    a,           // tap sample
    input  corr_data_pkg::coef_t      b,           // coefficient, sampled at stage one
    input  logic                      in_valid,
    output corr_data_pkg::prod_t      p,           // a * b after MULT_LAT cycles
    output logic                      out_valid
);

localparam int LAT = corr_data_pkg::MULT_LAT;

logic signed [29:0]   a1_r, a2_r;                  // a port width of the slice
logic signed [17:0]   b1_r, b2_r;                  // b port width of the slice
corr_data_pkg::prod_t m_r;                         // product register
corr_data_pkg::prod_t p_r;                         // output register
logic [LAT-1:0]       vld_sr;                      // valid alongside the data

// data pipeline, operands widened on entry
always_ff @(posedge clk) begin
    a1_r <= {{14{a[15]}}, a};
    b1_r <= {{2{b[15]}}, b};
    a2_r <= a1_r;                                  // second input stage
    b2_r <= b1_r;
    m_r  <= a2_r * b2_r;                           // signed, evaluated at 48 bits
    p_r  <= m_r;
end

// one valid bit per stage, up to four products in flight
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        vld_sr <= '0;
    end else begin
        vld_sr <= {vld_sr[LAT-2:0], in_valid};
    end
end

assign p         = p_r;
assign out_valid = vld_sr[LAT-1];

endmodule

`default_nettype wire

// ==== design/corr_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_sum #(
    parameter int NUM_TAPS = 8                             // number of products to add
)
(
    input  logic                                  clk,
    input  logic                                  arst_n,

    input  corr_data_pkg::prod_t [NUM_TAPS-1:0]   prods,        // one product per tap
    input  logic                                  prods_valid,  // from tap 0
    input  corr_data_pkg::corr_t                  thresh,       // peak threshold
    output corr_data_pkg::corr_out_t              corr          // result with flags
);

localparam int LAT = corr_data_pkg::SUM_LAT;

corr_data_pkg::corr_t sum_c;                               // combinational adder
corr_data_pkg::corr_t sum_r;                               // stage one
corr_data_pkg::corr_t value_r;                             // stage two
logic                 peak_r;                              // stage two compare
logic [LAT-1:0]       vld_sr;                              // [0] stage one, top is output

// adder over all taps, wraps modulo 2^48
always_comb begin
    sum_c = '0;
    for (int i = 0; i < NUM_TAPS; i++) begin
        sum_c = sum_c + prods[i];
    end
end

// stage one registers the sum
always_ff @(posedge clk) begin
    sum_r <= sum_c;
end

// stage two holds the value
always_ff @(posedge clk) begin
    value_r <= sum_r;
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        vld_sr <= '0;
        peak_r <= 1'b0;
    end else begin
        vld_sr <= {vld_sr[LAT-2:0], prods_valid};          // valid through both stages
        peak_r <= vld_sr[0] && (sum_r > thresh);           // signed compare, qualified
    end
end

// pack the output struct
assign corr = '{
    valid: vld_sr[LAT-1],
    value: value_r,
    peak:  peak_r
};

endmodule

`default_nettype wire

// ==== design/shift_corr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_corr_top #(
    parameter int NUM_TAPS = 8                               // 1 to 15 taps
)
(
    input  logic                          clk,
    input  logic                          arst_n,

    input  corr_cfg_pkg::cfg_wr_t         cfg,               // register writes
    input  corr_data_pkg::sample_t        sample,            // sample stream
    input  logic                          sample_valid,
    output corr_data_pkg::corr_out_t      corr               // 7 cycles after the strobe
);

corr_data_pkg::coef_t   [NUM_TAPS-1:0] coefs;                // coefficient bank
corr_data_pkg::corr_t                  thresh;               // peak threshold
corr_data_pkg::sample_t [NUM_TAPS-1:0] taps;                 // delay line outputs
logic                                  taps_valid;
corr_data_pkg::prod_t   [NUM_TAPS-1:0] prods;                // per tap products
logic                                  prods_valid;          // tap 0 valid

coef_regs #(
    .NUM_TAPS (NUM_TAPS)
)
u_coef_regs (
    .clk    (clk),
    .arst_n (arst_n),
    .cfg    (cfg),
    .coefs  (coefs),
    .thresh (thresh)
);

sample_delay_line #(
    .NUM_TAPS (NUM_TAPS)
)
u_delay_line (
    .clk          (clk),
    .arst_n       (arst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .taps         (taps),
    .taps_valid   (taps_valid)
);

// one multiplier per tap, all pipelines run in lock step
for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    if (k == 0) begin : g_lead
        tap_mult u_mult (
            .clk       (clk),
            .arst_n    (arst_n),
            .a         (taps[k]),
            .b         (coefs[k]),
            .in_valid  (taps_valid),
            .p         (prods[k]),
            .out_valid (prods_valid)                         // stands for all taps
        );
    end else begin : g_rest
        tap_mult u_mult (
            .clk       (clk),
            .arst_n    (arst_n),
            .a         (taps[k]),
            .b         (coefs[k]),
            .in_valid  (taps_valid),
            .p         (prods[k]),
            .out_valid ()                                    // same timing as tap 0
        );
    end
end

corr_sum #(
    .NUM_TAPS (NUM_TAPS)
)
u_corr_sum (
    .clk         (clk),
    .arst_n      (arst_n),
    .prods       (prods),
    .prods_valid (prods_valid),
    .thresh      (thresh),
    .corr        (corr)
);

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS  = 40,                    // clock period
    parameter int RST_CYCLES = 8                      // rising edges spent in reset
)
(
    output logic clk,
    output logic arst_n
);

initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;              // free running
end

initial begin
    arst_n = 1'b0;                                    // in reset from time zero
    repeat (RST_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;                                 // released just after an edge
end

endmodule

`default_nettype wire

// ==== bench/shift_corr_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_corr_sva (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         sample_valid,
    input corr_data_pkg::corr_out_t     corr
);

// strobe to result through the delay line, multiply and sum
localparam int LAT = 1 + corr_data_pkg::MULT_LAT + corr_data_pkg::SUM_LAT;

int fail_count = 0;                                   // failed assertions so far

property p_result_follows;
    @(posedge clk) disable iff (!arst_n)
        sample_valid |-> ##LAT corr.valid;            // every sample gives a result
endproperty

property p_no_orphan;
    @(posedge clk) disable iff (!arst_n)
        corr.valid |-> $past(sample_valid, LAT);     // no result without its sample
endproperty

property p_peak_qualified;
    @(posedge clk) corr.peak |-> corr.valid;
endproperty

property p_quiet_in_reset;
    @(posedge clk) !arst_n |-> !corr.valid;
endproperty

a_result_follows: assert property (p_result_follows)
    else begin
        $error("corr.valid missing %0d cycles after sample_valid", LAT);
        fail_count++;
    end
a_no_orphan: assert property (p_no_orphan)
    else begin
        $error("corr.valid without a sample %0d cycles earlier", LAT);
        fail_count++;
    end
a_peak_qualified: assert property (p_peak_qualified)
    else begin
        $error("corr.peak high while corr.valid is low");
        fail_count++;
    end
a_quiet_in_reset: assert property (p_quiet_in_reset)
    else begin
        $error("corr.valid high during reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== bench/shift_corr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_corr_tb;

localparam int          NUM_TAPS  = 8;
localparam int          FLUSH     = 8;                   // idle cycles closing each test
localparam logic [31:0] SEED      = 32'hae677efd;

localparam int SK_IMPULSE = 0;                           // 1 then zeros
localparam int SK_RANDOM  = 1;
localparam int SK_EXTREME = 2;                           // each sample -32768 or 32767
localparam int SK_RAMP    = 3;                           // small spread values
localparam int SK_MIN     = 4;                           // all -32768
localparam int CK_RAMP    = 0;
localparam int CK_RANDOM  = 1;
localparam int CK_EXTREME = 2;
localparam int CK_MIN     = 3;

typedef struct packed {
    int samp_kind;
    int coef_kind;
    int thresh;                                          // sign extended by the DUT
    int len;                                             // samples in the test
    int max_gap;                                         // idle cycles drawn between strobes
} test_t;

typedef struct packed {
    logic signed [47:0] value;
    logic               peak;
} exp_t;

localparam int NUM_TESTS = 7;
localparam test_t TESTS [NUM_TESTS] = '{
    '{SK_IMPULSE, CK_RAMP,    0,          12, 0},        // straight after reset
    '{SK_RANDOM,  CK_RANDOM,  0,          40, 0},        // back to back
    '{SK_RANDOM,  CK_RANDOM,  0,          30, 5},        // irregular gaps
    '{SK_RAMP,    CK_RAMP,    1000000,    24, 0},        // positive threshold
    '{SK_RAMP,    CK_RAMP,    -1000000,   24, 2},        // negative threshold
    '{SK_EXTREME, CK_EXTREME, 0,          20, 0},
    '{SK_MIN,     CK_MIN,     2147483647, 10, 0}         // 2^33 sum beats the top threshold
};

logic                      clk;
logic                      arst_n;
corr_cfg_pkg::cfg_wr_t     cfg;
corr_data_pkg::sample_t    sample;
logic                      sample_valid;
corr_data_pkg::corr_out_t  corr;

corr_data_pkg::coef_t      model_coef [NUM_TAPS];      // software copy of the bank
corr_data_pkg::sample_t    model_line [NUM_TAPS];      // software delay line
longint                    model_thresh;
exp_t                      exp_q [$];                  // written by the driver only
int                        valid_seen  = 0;            // written by the monitor only
int                        mon_errors  = 0;
int                        mon_checks  = 0;
int                        main_errors = 0;
int                        main_checks = 0;
int                        cur_test    = -1;

clk_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) clk0 (.clk(clk), .arst_n(arst_n));

shift_corr_top #(
    .NUM_TAPS (NUM_TAPS)
)
dut0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .cfg          (cfg),
    .sample       (sample),
    .sample_valid (sample_valid),
    .corr         (corr)
);

bind shift_corr_top shift_corr_sva sva0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .sample_valid (sample_valid),
    .corr         (corr)
);

task automatic step();
    @(posedge clk);
    #1;                                                  // inputs move just after the edge
endtask

task automatic write_cfg(input int addr, input int data);
    cfg = '{en:   1'b1,
            addr: corr_cfg_pkg::cfg_addr_t'(addr),
            data: corr_cfg_pkg::cfg_data_t'(data)};
    step();
    cfg.en = 1'b0;
endtask

function automatic corr_data_pkg::coef_t pick_coef(input int kind, input int k);
    case (kind)
        CK_RAMP:    return corr_data_pkg::coef_t'(1500 * k - 4999);
        CK_RANDOM:  return corr_data_pkg::coef_t'($urandom);
        CK_EXTREME: return ($urandom_range(1, 0) == 1) ? 16'sh7fff : 16'sh8000;
        default:    return 16'sh8000;
    endcase
endfunction

function automatic corr_data_pkg::sample_t pick_sample(input int kind, input int i);
    case (kind)
        SK_IMPULSE: return corr_data_pkg::sample_t'((i == 0) ? 1 : 0);
        SK_RANDOM:  return corr_data_pkg::sample_t'($urandom);
        SK_EXTREME: return ($urandom_range(1, 0) == 1) ? 16'sh7fff : 16'sh8000;
        SK_RAMP:    return corr_data_pkg::sample_t'((i * 1237) % 4001 - 2000);
        default:    return 16'sh8000;
    endcase
endfunction

function automatic string kind_name(input int kind);
    case (kind)
        SK_IMPULSE: return "impulse";
        SK_RANDOM:  return "random";
        SK_EXTREME: return "extreme";
        SK_RAMP:    return "threshold";
        default:    return "all minimum";
    endcase
endfunction

// worst case cycles for the whole table
function automatic int table_cycles();
    int total;
    total = 0;
    for (int n = 0; n < NUM_TESTS; n++) begin
        total += TESTS[n].len * (1 + TESTS[n].max_gap) + NUM_TAPS + 2 + FLUSH;
    end
    return total;
endfunction

task automatic configure(input test_t t);
    corr_data_pkg::coef_t c;
    for (int k = 0; k < NUM_TAPS; k++) begin
        c = pick_coef(t.coef_kind, k);
        model_coef[k] = c;
        write_cfg(k, int'(c));
    end
    write_cfg(int'(corr_cfg_pkg::THRESH_ADDR), t.thresh);
    model_thresh = longint'(t.thresh);
    write_cfg(NUM_TAPS + 2, 32'h0000_5a5a);              // unused address leaves the bank as is
endtask

// model shifts only on a strobe, so gaps leave the expected stream unchanged
task automatic send_sample(input corr_data_pkg::sample_t s);
    exp_t   e;
    longint acc;
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
        model_line[k] = model_line[k-1];
    end
    model_line[0] = s;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
        acc += longint'(model_line[k]) * longint'(model_coef[k]);
    end
    e.value = 48'(acc);
    e.peak  = (acc > model_thresh);
    exp_q.push_back(e);
    sample       = s;
    sample_valid = 1'b1;
    step();
    sample_valid = 1'b0;
endtask

// compare at the falling edge where corr is settled
always @(negedge clk) begin
    if (arst_n && corr.valid) begin
        mon_checks++;
        assert (valid_seen < exp_q.size()) else begin
            $display("unexpected valid pulse at %0t in test %0d", $time, cur_test);
            mon_errors++;
        end
        if (valid_seen < exp_q.size()) begin
            assert (corr.value == exp_q[valid_seen].value
                    && corr.peak == exp_q[valid_seen].peak) else begin
                $display({"MISMATCH at %0t: test %0d output %0d value %0d peak %b,",
                          " expected %0d peak %b"},
                         $time, cur_test, valid_seen, corr.value, corr.peak,
                         exp_q[valid_seen].value, exp_q[valid_seen].peak);
                mon_errors++;
            end
        end
        valid_seen++;
    end
end

initial begin
    int    base_err;
    int    base_seen;
    int    gap;
    int    sva_fails;
    test_t t;
    void'($urandom(SEED));
    cfg          = '0;
    sample       = '0;
    sample_valid = 1'b0;
    model_thresh = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
        model_line[k] = '0;                              // unfilled taps read as zero
        model_coef[k] = '0;
    end
    wait (arst_n === 1'b1);
    step();
    main_checks++;
    assert (corr.valid == 1'b0 && corr.peak == 1'b0) else begin
        $display("outputs active right after reset at %0t", $time);
        main_errors++;
    end
    for (int n = 0; n < NUM_TESTS; n++) begin
        t         = TESTS[n];
        cur_test  = n;
        base_err  = main_errors + mon_errors;
        base_seen = valid_seen;
        configure(t);                                    // stream is idle here
        for (int i = 0; i < t.len; i++) begin
            send_sample(pick_sample(t.samp_kind, i));
            if (t.max_gap > 0) begin
                gap = int'($urandom_range(t.max_gap, 0));
                repeat (gap) step();
            end
        end
        repeat (FLUSH) step();
        main_checks++;
        assert (valid_seen - base_seen == t.len && valid_seen == exp_q.size()) else begin
            $display("test %0d gave %0d valid pulses for %0d samples",
                     n, valid_seen - base_seen, t.len);
            main_errors++;
        end
        $display("test %0d %s, gap %0d: %0d samples, %0d errors", n, kind_name(t.samp_kind),
                 t.max_gap, t.len, main_errors + mon_errors - base_err);
    end
    sva_fails = dut0.sva0.fail_count;                    // bound checker failures
    main_checks++;
    assert (sva_fails == 0) else begin
        $display("%0d bound assertion failures during the run", sva_fails);
        main_errors++;
    end
    $display("checks %0d, errors %0d", main_checks + mon_checks, main_errors + mon_errors);
    if (main_errors + mon_errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

// run limit from the table length
initial begin
    int cycles;
    int limit;
    cycles = 0;
    limit  = 2 * table_cycles() + 200;
    while (cycles < limit) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Something failed");
    $finish;
end

endmodule

`default_nettype wire

// ==== files.f ====
design/corr_data_pkg.sv
design/corr_cfg_pkg.sv
design/coef_regs.sv
design/sample_delay_line.sv
design/tap_mult.sv
design/corr_sum.sv
design/shift_corr_top.sv
bench/clk_gen.sv
bench/shift_corr_sva.sv
bench/shift_corr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       := shift_corr_tb
FILELIST  := files.f
OBJDIR    := obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
